// File: run_sim.sh
#!/bin/sh
# Build and run the LUT sharing testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=vn_lut_share_sim

verilator --binary --timing --assert -j 0 \
	--top-module vn_lut_share_tb \
	-f vn_lut_share_top.f \
	-o "$sim_bin"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result is decided by the message line in the log
if grep -qx "sim passed" "$log_file"; then
	exit 0
fi
echo "Pass line not found in $log_file"
exit 1

// File: source/vn_lut_banks.sv
`timescale 1ns/1ns

module vn_lut_banks (
	input  logic                                read_clk,
	input  logic                                rstn,
	input  logic [vn_lut_pkg::quan_w-1:0]       wr_din_high,
	input  logic [vn_lut_pkg::quan_w-1:0]       wr_din_low,
	input  logic [vn_lut_pkg::entry_addr_w-1:0] write_addr,
	input  logic                                we,
	lut_rd_if.bank                              rd,
	lut_dat_if.bank                             dat
);
	import vn_lut_pkg::*;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	// High column group, duplicated so both requestors read at once
	logic [quan_w-1:0] mem_high [high_copies][lut_depth];

	// Low column group, a single bank shared through the arbiter
	logic [quan_w-1:0] mem_low [lut_depth];

	logic [entry_addr_w-1:0] rd_addr_high [high_copies];
	logic [entry_addr_w-1:0] rd_addr_low;

	// Iteration offset picks the upper or lower half of each bank
	assign rd_addr_high[0] = {rd.iter, rd.addr_high_0};
	assign rd_addr_high[1] = {rd.iter, rd.addr_high_1};
	assign rd_addr_low     = {rd.iter, rd.addr_low};

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Both high copies always hold the same table
	always_ff @(posedge read_clk) begin
		if (we) begin
			for (int c = 0; c < high_copies; c++) begin
				mem_high[c][write_addr] <= wr_din_high;
			end
			mem_low[write_addr] <= wr_din_low;
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read, stage 2
	////////////////////////////////////////////////////////////

	// A write at the same edge is not seen here, the old word comes out
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			dat.data_high_0 <= '0;
			dat.data_high_1 <= '0;
			dat.data_low    <= '0;
		end else begin
			dat.data_high_0 <= mem_high[0][rd_addr_high[0]];
			dat.data_high_1 <= mem_high[1][rd_addr_high[1]];
			dat.data_low    <= mem_low[rd_addr_low];
		end
	end

	// Selects and miss travel with the data they belong to
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			dat.sel_0 <= '0;
			dat.sel_1 <= '0;
			dat.miss  <= 1'b0;
		end else begin
			dat.sel_0 <= rd.sel_0;
			dat.sel_1 <= rd.sel_1;
			dat.miss  <= rd.miss;
		end
	end

endmodule

// File: source/vn_lut_if.sv
`timescale 1ns/1ns

// Granted read request, arbiter stage to bank stage
interface lut_rd_if;
	import vn_lut_pkg::*;

	logic [row_addr_w-1:0] addr_high_0; // Row for high copy 0
	logic [row_addr_w-1:0] addr_high_1; // Row for high copy 1
	logic [row_addr_w-1:0] addr_low;    // Row granted to the shared low bank
	logic iter;                         // Selects the iteration half
	logic [col_addr_w-1:0] sel_0;
	logic [col_addr_w-1:0] sel_1;
	logic miss;                         // Requestor 1 lost the low bank

	modport arb (
		output addr_high_0, addr_high_1, addr_low, iter, sel_0, sel_1, miss
	);

	modport bank (
		input addr_high_0, addr_high_1, addr_low, iter, sel_0, sel_1, miss
	);

endinterface

// Bank read words with their selects, bank stage to output switch
interface lut_dat_if;
	import vn_lut_pkg::*;

	logic [quan_w-1:0] data_high_0;
	logic [quan_w-1:0] data_high_1;
	logic [quan_w-1:0] data_low;
	logic [col_addr_w-1:0] sel_0; // One stage behind the read request
	logic [col_addr_w-1:0] sel_1;
	logic miss;

	modport bank (
		output data_high_0, data_high_1, data_low, sel_0, sel_1, miss
	);

	modport sw (
		input data_high_0, data_high_1, data_low, sel_0, sel_1, miss
	);

endinterface

// File: source/vn_lut_out_switch.sv
`timescale 1ns/1ns

module vn_lut_out_switch (
	lut_dat_if.sw                         dat,
	output logic [vn_lut_pkg::quan_w-1:0] dout_vnu_0,
	output logic [vn_lut_pkg::quan_w-1:0] dout_vnu_1,
	output logic                          rqst_1_miss
);
	import vn_lut_pkg::*;

	logic [quan_w-1:0] high_word [vn_group_size]; // Private high copy per unit
	logic [vn_group_size-1:0] low_sel;
	logic [quan_w-1:0] vnu_word [vn_group_size];

	assign high_word[0] = dat.data_high_0;
	assign high_word[1] = dat.data_high_1;

	// One select bit per variable-node unit
	assign low_sel = {dat.sel_1, dat.sel_0};

	////////////////////////////////////////////////////////////
	// Per-unit 2:1 selection
	////////////////////////////////////////////////////////////

	// Every unit sees the one low word, only the winner's is meaningful
	for (genvar v = 0; v < vn_group_size; v++) begin : g_vnu
		assign vnu_word[v] = low_sel[v] ? dat.data_low : high_word[v];
	end

	assign dout_vnu_0 = vnu_word[0];
	assign dout_vnu_1 = vnu_word[1];

	assign rqst_1_miss = dat.miss; // Flags dout_vnu_1 as invalid

endmodule

// File: source/vn_lut_pkg.sv
package vn_lut_pkg;

	////////////////////////////////////////////////////////////
	// Sharing group
	////////////////////////////////////////////////////////////

	// Variable-node units that share one bank group
	localparam int vn_group_size = 2;

	// Parallel copies of the high column-group bank, one per requestor
	localparam int high_copies = 2;

	////////////////////////////////////////////////////////////
	// Addressing
	////////////////////////////////////////////////////////////

	// Column-group select, 0 for the high group and 1 for the low group
	localparam int col_addr_w = 1;

	localparam int row_addr_w = 4; // Row inside one iteration half

	// Entry address is {iteration offset, row}
	localparam int entry_addr_w = row_addr_w + 1;

	localparam int lut_depth = 1 << entry_addr_w; // 32 entries per bank

	////////////////////////////////////////////////////////////
	// Data
	////////////////////////////////////////////////////////////

	// Quantised message word stored in every lookup table
	localparam int quan_w = 3;

endpackage

// File: source/vn_lut_rqst_arbiter.sv
`timescale 1ns/1ns

module vn_lut_rqst_arbiter (
	input  logic                              read_clk,
	input  logic                              rstn,
	input  logic [vn_lut_pkg::col_addr_w-1:0] col_addr_rqst_0,
	input  logic [vn_lut_pkg::col_addr_w-1:0] col_addr_rqst_1,
	input  logic [vn_lut_pkg::row_addr_w-1:0] row_addr_rqst_0,
	input  logic [vn_lut_pkg::row_addr_w-1:0] row_addr_rqst_1,
	input  logic                              rd_multi_iter_offset,
	lut_rd_if.arb                             rd
);
	import vn_lut_pkg::*;

	logic rqst_0_low;                 // Requestor 0 asks for the low group
	logic rqst_1_low;                 // Requestor 1 asks for the low group
	logic [row_addr_w-1:0] grant_row_low;
	logic conflict;

	////////////////////////////////////////////////////////////
	// Low bank grant
	////////////////////////////////////////////////////////////

	assign rqst_0_low = col_addr_rqst_0[0];
	assign rqst_1_low = col_addr_rqst_1[0];

	// Requestor 0 has fixed priority on the single low bank,
	// requestor 1 only gets it while requestor 0 reads high
	assign grant_row_low = rqst_0_low ? row_addr_rqst_0 : row_addr_rqst_1;

	// Both want the low bank, so requestor 1's word will be wrong
	assign conflict = rqst_0_low & rqst_1_low;

	////////////////////////////////////////////////////////////
	// Stage 1 register
	////////////////////////////////////////////////////////////

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			rd.addr_high_0 <= '0;
			rd.addr_high_1 <= '0;
			rd.addr_low    <= '0;
			rd.iter        <= 1'b0;
			rd.sel_0       <= '0;
			rd.sel_1       <= '0;
			rd.miss        <= 1'b0;
		end else begin
			// Each high copy is private, no arbitration needed there
			rd.addr_high_0 <= row_addr_rqst_0;
			rd.addr_high_1 <= row_addr_rqst_1;
			rd.addr_low    <= grant_row_low;
			rd.iter        <= rd_multi_iter_offset;
			rd.sel_0       <= col_addr_rqst_0; // Steers the output switch later
			rd.sel_1       <= col_addr_rqst_1;
			rd.miss        <= conflict;
		end
	end

endmodule

// File: source/vn_lut_share_top.sv
`timescale 1ns/1ns

module vn_lut_share_top (
	input  logic                                read_clk,
	input  logic                                rstn,

	// Column-group selects, 0 high and 1 low
	input  logic [vn_lut_pkg::col_addr_w-1:0]   col_addr_rqst_0,
	input  logic [vn_lut_pkg::col_addr_w-1:0]   col_addr_rqst_1,

	// Row addresses
	input  logic [vn_lut_pkg::row_addr_w-1:0]   row_addr_rqst_0,
	input  logic [vn_lut_pkg::row_addr_w-1:0]   row_addr_rqst_1,
	input  logic                                rd_multi_iter_offset,

	// Table load port
	input  logic [vn_lut_pkg::quan_w-1:0]       wr_din_high,
	input  logic [vn_lut_pkg::quan_w-1:0]       wr_din_low,
	input  logic [vn_lut_pkg::entry_addr_w-1:0] write_addr,
	input  logic                                we,

	output logic [vn_lut_pkg::quan_w-1:0]       dout_vnu_0,
	output logic [vn_lut_pkg::quan_w-1:0]       dout_vnu_1,
	output logic                                rqst_1_miss
);

	lut_rd_if  rd_bus ();  // Granted addresses, after stage 1
	lut_dat_if dat_bus (); // Bank words, after stage 2

	////////////////////////////////////////////////////////////
	// Stage 1, request arbitration
	////////////////////////////////////////////////////////////

	vn_lut_rqst_arbiter vn_lut_rqst_arbiter_inst (
		.read_clk             (read_clk),
		.rstn                 (rstn),
		.col_addr_rqst_0      (col_addr_rqst_0),
		.col_addr_rqst_1      (col_addr_rqst_1),
		.row_addr_rqst_0      (row_addr_rqst_0),
		.row_addr_rqst_1      (row_addr_rqst_1),
		.rd_multi_iter_offset (rd_multi_iter_offset),
		.rd                   (rd_bus.arb)
	);

	////////////////////////////////////////////////////////////
	// Stage 2, lookup-table banks
	////////////////////////////////////////////////////////////

	vn_lut_banks vn_lut_banks_inst (
		.read_clk    (read_clk),
		.rstn        (rstn),
		.wr_din_high (wr_din_high),
		.wr_din_low  (wr_din_low),
		.write_addr  (write_addr),
		.we          (we),
		.rd          (rd_bus.bank),
		.dat         (dat_bus.bank)
	);

	// Output routing, no register here
	vn_lut_out_switch vn_lut_out_switch_inst (
		.dat         (dat_bus.sw),
		.dout_vnu_0  (dout_vnu_0),
		.dout_vnu_1  (dout_vnu_1),
		.rqst_1_miss (rqst_1_miss)
	);

endmodule

// File: tests/vn_lut_share_assert.sv
`timescale 1ns/1ns

module vn_lut_share_assert (
	input logic                            read_clk,
	input logic                            rstn,
	input logic [vn_lut_pkg::col_addr_w-1:0] col_addr_rqst_0,
	input logic [vn_lut_pkg::col_addr_w-1:0] col_addr_rqst_1,
	input logic [vn_lut_pkg::quan_w-1:0]   dout_vnu_0,
	input logic [vn_lut_pkg::quan_w-1:0]   dout_vnu_1,
	input logic                            rqst_1_miss
);

	////////////////////////////////////////////////////////////
	// Miss flag
	////////////////////////////////////////////////////////////

	// Pipeline is cleared by every reset edge
	miss_low_in_reset: assert property (@(posedge read_clk) !rstn |=> !rqst_1_miss)
		else $error("rqst_1_miss high while in reset");

	miss_on_conflict: assert property (@(posedge read_clk) disable iff (!rstn)
		(col_addr_rqst_0[0] & col_addr_rqst_1[0]) |-> ##2 rqst_1_miss)
		else $error("rqst_1_miss missing two cycles after a low bank conflict");

	miss_only_on_conflict: assert property (@(posedge read_clk) disable iff (!rstn)
		!(col_addr_rqst_0[0] & col_addr_rqst_1[0]) |-> ##2 !rqst_1_miss)
		else $error("rqst_1_miss raised without a low bank conflict");

	outputs_known: assert property (@(posedge read_clk) disable iff (!rstn)
		!$isunknown({dout_vnu_0, dout_vnu_1, rqst_1_miss}))
		else $error("Output unknown after reset");

endmodule

bind vn_lut_share_top vn_lut_share_assert vn_lut_share_assert_inst (
	.read_clk        (read_clk),
	.rstn            (rstn),
	.col_addr_rqst_0 (col_addr_rqst_0),
	.col_addr_rqst_1 (col_addr_rqst_1),
	.dout_vnu_0      (dout_vnu_0),
	.dout_vnu_1      (dout_vnu_1),
	.rqst_1_miss     (rqst_1_miss)
);

// File: tests/vn_lut_share_tb.sv
`timescale 1ns/1ns

module vn_lut_share_tb;
	import vn_lut_pkg::*;

	localparam int clk_period   = 20;
	localparam int reset_cycles = 8;
	localparam int stream_len   = 200;
	// Cycles spent by every test including the drain after each one
	localparam int test_cycles  = reset_cycles + 1 + (lut_depth + 7) + 7 + 6 + 11
		+ (stream_len + 6);
	localparam int timeout_ns   = (test_cycles + 200) * clk_period;

	logic read_clk;
	logic rstn;
	logic [col_addr_w-1:0] col_addr_rqst_0;
	logic [col_addr_w-1:0] col_addr_rqst_1;
	logic [row_addr_w-1:0] row_addr_rqst_0;
	logic [row_addr_w-1:0] row_addr_rqst_1;
	logic rd_multi_iter_offset;
	logic [quan_w-1:0] wr_din_high;
	logic [quan_w-1:0] wr_din_low;
	logic [entry_addr_w-1:0] write_addr;
	logic we;
	logic [quan_w-1:0] dout_vnu_0;
	logic [quan_w-1:0] dout_vnu_1;
	logic rqst_1_miss;

	logic [quan_w-1:0] model_high [lut_depth]; // Reference tables
	logic [quan_w-1:0] model_low [lut_depth];

	// Expected results tagged with the cycle they become valid
	int q_due[$];
	logic [quan_w-1:0] q_d0[$];
	logic [quan_w-1:0] q_d1[$];
	logic q_miss[$];
	bit q_chk1[$];

	int cyc = 0;
	int checks = 0;
	int errors = 0;
	int unsigned lcg_state = 73126;

	vn_lut_share_top vn_lut_share_top_inst (.*);

	initial begin
		read_clk = 1'b0;
		forever #(clk_period / 2) read_clk = ~read_clk;
	end

	always @(posedge read_clk) cyc <= cyc + 1;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	// Preload words where every address bit has an effect
	function automatic logic [quan_w-1:0] fill_high(input logic [entry_addr_w-1:0] a);
		return a[2:0] ^ {1'b0, a[4:3]};
	endfunction

	function automatic logic [quan_w-1:0] fill_low(input logic [entry_addr_w-1:0] a);
		return ~a[2:0] ^ {a[4:3], 1'b1};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// One request per cycle with an optional write at the same edge
	task automatic drive_req(input logic c0, input logic c1,
			input logic [row_addr_w-1:0] r0, input logic [row_addr_w-1:0] r1,
			input logic it, input logic wr, input logic [entry_addr_w-1:0] wa,
			input logic [quan_w-1:0] dh, input logic [quan_w-1:0] dl);
		logic [quan_w-1:0] e0;
		logic [quan_w-1:0] e1;
		@(posedge read_clk);
		col_addr_rqst_0 <= c0;
		col_addr_rqst_1 <= c1;
		row_addr_rqst_0 <= r0;
		row_addr_rqst_1 <= r1;
		rd_multi_iter_offset <= it;
		we <= wr;
		write_addr <= wa;
		wr_din_high <= dh;
		wr_din_low <= dl;
		// This request reaches the banks one edge after the write lands
		if (wr) begin
			model_high[wa] = dh;
			model_low[wa] = dl;
		end
		// Low select reads the shared bank and requestor 0 wins a conflict
		e0 = c0 ? model_low[{it, r0}] : model_high[{it, r0}];
		e1 = c1 ? model_low[{it, r1}] : model_high[{it, r1}];
		q_due.push_back(cyc + 3);
		q_d0.push_back(e0);
		q_d1.push_back(e1);
		q_miss.push_back(c0 & c1);
		q_chk1.push_back(!(c0 & c1));
	endtask

	task automatic wait_results();
		@(posedge read_clk);
		we <= 1'b0;
		while (q_due.size() != 0) @(negedge read_clk);
	endtask

	// Compare outputs in the middle of the cycle they are due
	initial begin
		forever begin
			@(negedge read_clk);
			if (q_due.size() != 0 && q_due[0] == cyc) begin
				check_value(32'(dout_vnu_0), 32'(q_d0[0]), "dout_vnu_0");
				if (q_chk1[0]) check_value(32'(dout_vnu_1), 32'(q_d1[0]), "dout_vnu_1");
				check_value(32'(rqst_1_miss), 32'(q_miss[0]), "rqst_1_miss");
				void'(q_due.pop_front());
				void'(q_d0.pop_front());
				void'(q_d1.pop_front());
				void'(q_miss.pop_front());
				void'(q_chk1.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// Loads the first entries while the pipeline is held in reset
	// and a low bank conflict sits on the request inputs
	task automatic reset_and_preload();
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge read_clk);
			if (i == reset_cycles - 1) begin
				rstn <= 1'b1;
				we <= 1'b0;
				col_addr_rqst_0 <= '0;
				col_addr_rqst_1 <= '0;
			end else begin
				we <= 1'b1;
				col_addr_rqst_0 <= 1'b1;
				col_addr_rqst_1 <= 1'b1;
				write_addr <= 5'(i);
				wr_din_high <= fill_high(5'(i));
				wr_din_low <= fill_low(5'(i));
				model_high[i] = fill_high(5'(i));
				model_low[i] = fill_low(5'(i));
			end
		end
	endtask

	task automatic outputs_after_reset();
		@(negedge read_clk);
		check_value(32'(dout_vnu_0), 0, "dout_vnu_0 after reset");
		check_value(32'(dout_vnu_1), 0, "dout_vnu_1 after reset");
		check_value(32'(rqst_1_miss), 0, "rqst_1_miss after reset");
	endtask

	task automatic high_group_reads();
		int unsigned r;
		$display("High group reads after a full table load");
		for (int i = 0; i < lut_depth; i++) begin
			r = next_rand();
			drive_req(1'b0, 1'b0, 4'd0, 4'd0, 1'b0, 1'b1, 5'(i), r[2:0], r[5:3]);
		end
		drive_req(1'b0, 1'b0, 4'd3, 4'd12, 1'b0, 1'b0, 5'd0, 3'd0, 3'd0);
		drive_req(1'b0, 1'b0, 4'd7, 4'd9, 1'b1, 1'b0, 5'd0, 3'd0, 3'd0);
		wait_results();
	endtask

	task automatic shared_low_reads();
		$display("Low bank shared without conflict");
		drive_req(1'b1, 1'b0, 4'd4, 4'd11, 1'b0, 1'b0, 5'd0, 3'd0, 3'd0);
		drive_req(1'b0, 1'b1, 4'd2, 4'd13, 1'b1, 1'b0, 5'd0, 3'd0, 3'd0);
		wait_results();
	endtask

	task automatic low_bank_conflict();
		$display("Both requestors on the low bank");
		drive_req(1'b1, 1'b1, 4'd6, 4'd8, 1'b0, 1'b0, 5'd0, 3'd0, 3'd0);
		wait_results();
	endtask

	task automatic iter_offset_halves();
		int unsigned r;
		$display("Iteration offset halves");
		r = next_rand();
		// Halves get different words so a wrong offset shows up
		drive_req(1'b0, 1'b0, 4'd0, 4'd0, 1'b0, 1'b1, 5'd5, r[2:0], r[5:3]);
		drive_req(1'b0, 1'b0, 4'd0, 4'd0, 1'b0, 1'b1, 5'd21, r[2:0] ^ 3'd5, r[5:3] ^ 3'd6);
		drive_req(1'b0, 1'b0, 4'd0, 4'd0, 1'b0, 1'b1, 5'd10, r[8:6], r[11:9]);
		drive_req(1'b0, 1'b0, 4'd0, 4'd0, 1'b0, 1'b1, 5'd26, r[8:6] ^ 3'd3, r[11:9] ^ 3'd7);
		drive_req(1'b0, 1'b1, 4'd5, 4'd10, 1'b0, 1'b0, 5'd0, 3'd0, 3'd0);
		drive_req(1'b0, 1'b1, 4'd5, 4'd10, 1'b1, 1'b0, 5'd0, 3'd0, 3'd0);
		wait_results();
	endtask

	task automatic random_back_to_back();
		int unsigned r;
		int unsigned w;
		logic [entry_addr_w-1:0] wa;
		logic [entry_addr_w-1:0] prev_entry;
		$display("Random back-to-back stream, %0d requests", stream_len);
		prev_entry = '0;
		for (int n = 0; n < stream_len; n++) begin
			r = next_rand();
			w = next_rand();
			wa = w[4:0];
			// Entry that the previous request reads at the write edge
			if (w[5]) wa = prev_entry;
			drive_req(r[0], r[1], r[5:2], r[9:6], r[10], r[12:11] == 2'b00, wa,
				w[8:6], w[11:9]);
			prev_entry = {r[10], r[5:2]};
		end
		wait_results();
	endtask

	initial begin
		rstn = 1'b0;
		col_addr_rqst_0 = '0;
		col_addr_rqst_1 = '0;
		row_addr_rqst_0 = '0;
		row_addr_rqst_1 = '0;
		rd_multi_iter_offset = 1'b0;
		wr_din_high = '0;
		wr_din_low = '0;
		write_addr = '0;
		we = 1'b0;
		reset_and_preload();
		outputs_after_reset();
		high_group_reads();
		shared_low_reads();
		low_bank_conflict();
		iter_offset_halves();
		random_back_to_back();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("Watchdog expired after %0d ns, tests did not finish", timeout_ns);
		$display("sim failed");
		$finish;
	end

endmodule

// File: vn_lut_share_top.f
source/vn_lut_pkg.sv
source/vn_lut_if.sv
source/vn_lut_rqst_arbiter.sv
source/vn_lut_banks.sv
source/vn_lut_out_switch.sv
source/vn_lut_share_top.sv
tests/vn_lut_share_assert.sv
tests/vn_lut_share_tb.sv
